//--- Makefile
# Verilator flow for the free list testbench

TOP := freelist_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

# build and run; status comes from the pass line in the output
sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

//--- all.f
+incdir+include
hw/rename_pkg.sv
hw/ring_counter.sv
hw/freelist_queue.sv
hw/checkpoint_store.sv
hw/restore_fsm.sv
hw/freelist_top.sv
bench/freelist_checker.sv
bench/freelist_tb.sv

//--- bench/freelist_checker.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module freelist_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  alloc_req,
    input  rename_pkg::release_t  rel,
    input  rename_pkg::ckpt_cmd_t ckpt,
    input  logic                  alloc_valid,
    input  rename_pkg::phys_tag_t alloc_tag,
    input  rename_pkg::fl_count_t free_count,
    output int                    error_count,
    output int                    check_count
);

    import rename_pkg::*;

    phys_tag_t            m_mem [`FL_DEPTH];
    fl_ptr_t              m_head;
    fl_ptr_t              m_tail;
    fl_ptr_t              m_saved [`NUM_CKPT];
    logic [`NUM_CKPT-1:0] m_page_valid;
    fl_ptr_t              m_fetched;  // pointer read out during rs_fetch
    restore_state_t       m_state;

    function automatic fl_ptr_t wrap_inc(input fl_ptr_t p);
        if (int'(p) == `FL_DEPTH - 1) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // expected free entries, tail minus head around the ring
    function automatic fl_count_t model_free();
        int diff;
        diff = int'(m_tail) - int'(m_head);
        if (diff < 0) begin
            diff = diff + `FL_DEPTH;
        end
        return fl_count_t'(diff);
    endfunction

    function automatic logic model_valid();
        return (model_free() != '0) && (m_state == rs_run);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR %s at %0t", msg, $time);
    endtask

    task automatic model_reset();
        for (int i = 0; i < `FL_DEPTH; i++) begin
            m_mem[i] = (i < `NUM_PHYS - `NUM_ARCH) ? phys_tag_t'(`NUM_ARCH + i) : '0;
        end
        m_head       = '0;
        m_tail       = fl_ptr_t'(`NUM_PHYS - `NUM_ARCH);
        m_page_valid = '0;
        m_fetched    = '0;
        m_state      = rs_run;
    endtask

    task automatic compare_outputs();
        logic exp_valid;
        exp_valid = model_valid();
        check_value("alloc_valid", 32'(exp_valid), 32'(alloc_valid));
        check_value("free_count", 32'(model_free()), 32'(free_count));
        if (exp_valid) begin
            check_value("alloc_tag", 32'(m_mem[m_head]), 32'(alloc_tag));
        end
    endtask

    // apply the inputs that the coming rising edge will see
    task automatic model_step();
        logic pop;
        pop = alloc_req && model_valid();
        case (m_state)
            rs_run: begin
                if (pop) begin
                    m_head = wrap_inc(m_head);  // rename before checkpoint
                end
                if (ckpt.save && ckpt.restore) begin
                    report_error("save and restore requested in the same cycle");
                end
                if (ckpt.save) begin
                    m_saved[ckpt.page]      = m_head;
                    m_page_valid[ckpt.page] = 1'b1;
                end else if (ckpt.restore) begin
                    if (!m_page_valid[ckpt.page]) begin
                        report_error("restore of a checkpoint page that was never saved");
                    end
                    m_fetched = m_saved[ckpt.page];
                    m_state   = rs_fetch;
                end
            end
            rs_fetch: begin
                if (ckpt.restore) begin
                    report_error("restore requested while a restore is running");
                end
                m_state = rs_load;
            end
            default: begin
                m_head  = m_fetched;
                m_state = rs_run;
            end
        endcase
        if (rel.en) begin
            m_mem[m_tail] = rel.tag;
            m_tail        = wrap_inc(m_tail);
        end
    endtask

    // mid-cycle sampling, inputs and outputs both settled
    always @(negedge clk) begin
        if (reset) begin
            model_reset();
        end else begin
            compare_outputs();
            model_step();
        end
    end

endmodule

//--- bench/freelist_tb.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module freelist_tb;

    import rename_pkg::*;

    localparam int reset_cycles    = 10;
    localparam int directed_cycles = 500;  // budget for the directed tests
    localparam int random_cycles   = 2500;
    localparam int max_cycles      = (reset_cycles + directed_cycles + random_cycles) * 4 / 3;

    logic        clk;
    logic        reset;
    logic        alloc_req;
    release_t    rel;
    ckpt_cmd_t   ckpt;
    logic        alloc_valid;
    phys_tag_t   alloc_tag;
    fl_count_t   free_count;
    int          error_count;
    int          check_count;
    int          cycle_count = 0;

    logic [31:0] lfsr_state;
    phys_tag_t   held_tags [$];  // allocated and not yet released in age order
    int          held_ids [$];
    int          alloc_id;
    int          saved_id [`NUM_CKPT];
    logic        page_ok [`NUM_CKPT];  // page may still be restored
    int          busy_left;

    freelist_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .alloc_req   (alloc_req),
        .rel         (rel),
        .ckpt        (ckpt),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .free_count  (free_count)
    );

    freelist_checker chk0 (
        .clk         (clk),
        .reset       (reset),
        .alloc_req   (alloc_req),
        .rel         (rel),
        .ckpt        (ckpt),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .free_count  (free_count),
        .error_count (error_count),
        .check_count (check_count)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout after %0d cycles, checks %0d, errors %0d",
                     cycle_count, check_count, error_count);
            $display("Regression failed");
            $finish;
        end
    end

    // taps 32 22 2 1
    function automatic logic step_lfsr();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], step_lfsr()};
        end
        return v;
    endfunction

    // called 1 ns after an edge, returns 1 ns after the next one
    task automatic drive_cycle(input logic req, input logic do_rel, input logic do_save,
                               input logic do_restore, input ckpt_page_t pg);
        logic blocked;
        logic restoring;
        int   id;
        blocked = (busy_left > 0);
        if (blocked) begin
            busy_left--;
        end
        restoring = do_restore && !do_save && !blocked && page_ok[pg];
        alloc_req = req;
        rel       = '0;
        ckpt      = '0;
        if (do_rel && !restoring && held_tags.size() > 0) begin
            rel.en  = 1'b1;
            rel.tag = held_tags.pop_front();  // commit order
            id      = held_ids.pop_front();
            for (int q = 0; q < `NUM_CKPT; q++) begin
                if (saved_id[q] < id) begin
                    page_ok[q] = 1'b0;  // younger tag committed past this branch
                end
            end
        end
        if (req && alloc_valid) begin
            alloc_id++;
            held_tags.push_back(alloc_tag);
            held_ids.push_back(alloc_id);
        end
        if (do_save) begin
            ckpt.save = 1'b1;
            ckpt.page = pg;
            if (!blocked) begin
                saved_id[pg] = alloc_id;  // recovery drops the save
                page_ok[pg]  = 1'b1;
            end
        end else if (restoring) begin
            ckpt.restore = 1'b1;
            ckpt.page    = pg;
            while (held_ids.size() > 0 && held_ids[$] > saved_id[pg]) begin
                void'(held_tags.pop_back());  // squashed tag goes back to the queue
                void'(held_ids.pop_back());
            end
            for (int q = 0; q < `NUM_CKPT; q++) begin
                if (saved_id[q] > saved_id[pg]) begin
                    page_ok[q] = 1'b0;
                end
            end
            busy_left = 2;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic alloc_cycles(input int n);
        repeat (n) begin
            drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, '0);
        end
    endtask

    task automatic release_cycles(input int n);
        repeat (n) begin
            drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, '0);
        end
    endtask

    task automatic save_page(input ckpt_page_t pg, input logic req);
        drive_cycle(req, 1'b0, 1'b1, 1'b0, pg);
    endtask

    task automatic restore_page(input ckpt_page_t pg);
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b1, pg);
        alloc_cycles(2);  // requests held during recovery
    endtask

    initial begin
        logic       req;
        logic       do_rel;
        logic       do_save;
        logic       do_restore;
        ckpt_page_t pg;

        clk        = 1'b0;
        reset      = 1'b1;
        alloc_req  = 1'b0;
        rel        = '0;
        ckpt       = '0;
        lfsr_state = 32'h5f78b73a;
        alloc_id   = 0;
        busy_left  = 0;
        for (int i = 0; i < `NUM_CKPT; i++) begin
            saved_id[i] = 0;
            page_ok[i]  = 1'b0;
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset contents drain in order
        while (held_tags.size() < `NUM_PHYS - `NUM_ARCH) begin
            alloc_cycles(1);
        end
        // empty queue, then one tag returned
        alloc_cycles(4);
        release_cycles(1);
        alloc_cycles(3);
        // returned tags follow FIFO order
        release_cycles(40);
        alloc_cycles(20);
        release_cycles(30);

        // single checkpoint with releases in between
        save_page(3'd0, 1'b0);
        alloc_cycles(8);
        release_cycles(4);
        restore_page(3'd0);
        alloc_cycles(10);

        // nested pages restored youngest first
        save_page(3'd1, 1'b1);
        alloc_cycles(3);
        save_page(3'd2, 1'b1);
        alloc_cycles(3);
        save_page(3'd3, 1'b0);
        alloc_cycles(3);
        restore_page(3'd3);
        alloc_cycles(2);
        restore_page(3'd2);
        restore_page(3'd1);
        alloc_cycles(2);
        // overwritten page keeps the newer head
        save_page(3'd4, 1'b0);
        alloc_cycles(3);
        save_page(3'd4, 1'b1);
        alloc_cycles(4);
        restore_page(3'd4);
        alloc_cycles(3);
        release_cycles(20);

        for (int n = 0; n < random_cycles; n++) begin
            req        = (take_bits(1) != 32'd0);
            do_rel     = (take_bits(1) != 32'd0);
            do_save    = (take_bits(3) == 32'd0);
            do_restore = (take_bits(4) == 32'd0);
            pg         = ckpt_page_t'(take_bits(3));
            drive_cycle(req, do_rel, do_save, do_restore, pg);
        end
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
        repeat (3) @(posedge clk);

        $display("cycles %0d, checks %0d, errors %0d", cycle_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- hw/checkpoint_store.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module checkpoint_store (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   save,
    input  logic                   restore,
    input  rename_pkg::ckpt_page_t page,
    input  rename_pkg::fl_ptr_t    save_ptr,
    output rename_pkg::fl_ptr_t    restored_ptr
);

    import rename_pkg::*;

    fl_ptr_t             saved_head [`NUM_CKPT];
    logic [`NUM_CKPT-1:0] page_valid;
    fl_ptr_t             read_q;

    // valid bits, a page stays valid until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            page_valid <= '0;
        end else if (save) begin
            page_valid[page] <= 1'b1;
        end
    end

    // saved pointers, overwritten by a later save to the same page
    always_ff @(posedge clk) begin
        if (save) begin
            saved_head[page] <= save_ptr;
        end
    end

    // read port, registered on the restore strobe
    always_ff @(posedge clk) begin
        if (restore) begin
            read_q <= saved_head[page];
        end
    end

    assign restored_ptr = read_q;

    a_restore_valid : assert property (
        @(posedge clk) disable iff (reset)
        restore |-> page_valid[page]
    ) else $error("checkpoint_store: restore of invalid page %0d", page);

    a_no_save_restore : assert property (
        @(posedge clk) disable iff (reset)
        !(save && restore)
    ) else $error("checkpoint_store: save and restore in same cycle");

endmodule

//--- hw/freelist_queue.sv
`timescale 1ns/1ps
`include "rename_settings.svh"

module freelist_queue (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pop,
    input  rename_pkg::release_t   rel,
    input  logic                   head_load,
    input  rename_pkg::fl_ptr_t    head_value,
    output rename_pkg::fl_ptr_t    head,
    output rename_pkg::phys_tag_t  head_tag,
    output rename_pkg::fl_count_t  free_count,
    output logic                   empty
);

    import rename_pkg::*;

    // tags not mapped to architectural state at reset
    localparam int free_at_reset = `NUM_PHYS - `NUM_ARCH;

    phys_tag_t tag_mem [`FL_DEPTH];

    fl_ptr_t   head_ptr;
    fl_ptr_t   tail_ptr;
    fl_ptr_t   head_next;
    fl_count_t occupancy;

    ring_counter #(
        .DEPTH       (`FL_DEPTH)
    ) head_ctr (
        .clk         (clk),
        .reset       (reset),
        .inc         (pop),
        .load        (head_load),
        .load_value  (head_value),
        .reset_value ('0),
        .value       (head_ptr)
    );

    ring_counter #(
        .DEPTH       (`FL_DEPTH)
    ) tail_ctr (
        .clk         (clk),
        .reset       (reset),
        .inc         (rel.en),
        .load        (1'b0),  // tail is never rolled back
        .load_value  ('0),
        .reset_value (fl_ptr_t'(free_at_reset)),
        .value       (tail_ptr)
    );

    // tag storage, filled with 32.. on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `FL_DEPTH; i++) begin
                if (i < free_at_reset) begin
                    tag_mem[i] <= phys_tag_t'(`NUM_ARCH + i);
                end
            end
        end else if (rel.en) begin
            tag_mem[tail_ptr] <= rel.tag;
        end
    end

    // head as it will be after this edge, used for checkpoint save
    always_comb begin
        if (head_load) begin
            head_next = head_value;
        end else if (pop) begin
            head_next = (head_ptr == fl_ptr_t'(`FL_DEPTH - 1)) ? '0 : head_ptr + 1'b1;
        end else begin
            head_next = head_ptr;
        end
    end

    // tail minus head, modulo depth
    assign occupancy = (tail_ptr >= head_ptr) ?
                       fl_count_t'(tail_ptr - head_ptr) :
                       fl_count_t'(`FL_DEPTH + tail_ptr - head_ptr);

    assign head       = head_next;
    assign head_tag   = tag_mem[head_ptr];
    assign free_count = occupancy;
    assign empty      = (occupancy == '0);

    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (reset)
        pop |-> !empty
    ) else $error("freelist_queue: pop while empty");

endmodule

//--- hw/freelist_top.sv
`timescale 1ns/1ps

module freelist_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  alloc_req,
    input  rename_pkg::release_t  rel,
    input  rename_pkg::ckpt_cmd_t ckpt,
    output logic                  alloc_valid,
    output rename_pkg::phys_tag_t alloc_tag,
    output rename_pkg::fl_count_t free_count
);

    import rename_pkg::*;

    logic    pop;
    logic    empty;
    logic    busy;
    logic    head_load;
    logic    ckpt_save;
    logic    ckpt_restore;
    fl_ptr_t head_next;
    fl_ptr_t restored_ptr;

    assign alloc_valid  = ~empty & ~busy;
    assign pop          = alloc_req & alloc_valid;   // ignored request is retried
    assign ckpt_save    = ckpt.save & ~busy;
    assign ckpt_restore = ckpt.restore & ~busy;

    freelist_queue queue0 (
        .clk        (clk),
        .reset      (reset),
        .pop        (pop),
        .rel        (rel),
        .head_load  (head_load),
        .head_value (restored_ptr),
        .head       (head_next),
        .head_tag   (alloc_tag),
        .free_count (free_count),
        .empty      (empty)
    );

    checkpoint_store ckpt0 (
        .clk          (clk),
        .reset        (reset),
        .save         (ckpt_save),
        .restore      (ckpt_restore),
        .page         (ckpt.page),
        .save_ptr     (head_next),   // includes same-cycle allocation
        .restored_ptr (restored_ptr)
    );

    restore_fsm fsm0 (
        .clk       (clk),
        .reset     (reset),
        .restore   (ckpt.restore),
        .busy      (busy),
        .head_load (head_load)
    );

endmodule

//--- hw/rename_pkg.sv
`include "rename_settings.svh"

package rename_pkg;

    // physical register tag, 0 .. NUM_PHYS-1
    typedef logic [$clog2(`NUM_PHYS)-1:0] phys_tag_t;

    // index into the free queue
    typedef logic [$clog2(`FL_DEPTH)-1:0] fl_ptr_t;

    // one extra bit so a full queue count fits
    typedef logic [$clog2(`FL_DEPTH):0] fl_count_t;

    // checkpoint page select
    typedef logic [$clog2(`NUM_CKPT)-1:0] ckpt_page_t;

    // tag handed back by commit
    typedef struct packed {
        logic      en;
        phys_tag_t tag;
    } release_t;

    // branch checkpoint command from rename / branch unit
    typedef struct packed {
        logic       save;     // branch renamed
        logic       restore;  // mispredict recovery
        ckpt_page_t page;
    } ckpt_cmd_t;

    // restore sequencing
    typedef enum logic [1:0] {
        rs_run   = 2'd0,  // normal allocation
        rs_fetch = 2'd1,  // page pointer being read
        rs_load  = 2'd2   // head reloaded this cycle
    } restore_state_t;

endpackage

//--- hw/restore_fsm.sv
`timescale 1ns/1ps

module restore_fsm (
    input  logic clk,
    input  logic reset,
    input  logic restore,
    output logic busy,
    output logic head_load
);

    import rename_pkg::*;

    restore_state_t state_q;
    restore_state_t state_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= rs_run;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            rs_run: begin
                if (restore) begin
                    state_d = rs_fetch;  // pointer is read this edge
                end
            end
            rs_fetch: begin
                state_d = rs_load;
            end
            rs_load: begin
                state_d = rs_run;  // head takes restored value
            end
            default: begin
                state_d = rs_run;
            end
        endcase
    end

    // allocation is blocked for both recovery cycles
    assign busy      = (state_q != rs_run);
    assign head_load = (state_q == rs_load);

    // a second mispredict must wait for the first to finish
    a_no_restore_busy : assert property (
        @(posedge clk) disable iff (reset)
        restore |-> !busy
    ) else $error("restore_fsm: restore while busy");

endmodule

//--- hw/ring_counter.sv
`timescale 1ns/1ps

module ring_counter #(
    parameter int DEPTH = 128
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               inc,
    input  logic               load,
    input  rename_pkg::fl_ptr_t load_value,
    input  rename_pkg::fl_ptr_t reset_value,
    output rename_pkg::fl_ptr_t value
);

    import rename_pkg::*;

    fl_ptr_t ptr_q;
    fl_ptr_t ptr_inc;

    // wrap at DEPTH, not at the vector width
    assign ptr_inc = (ptr_q == fl_ptr_t'(DEPTH - 1)) ? '0 : ptr_q + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr_q <= reset_value;
        end else if (load) begin
            ptr_q <= load_value;  // load wins over inc
        end else if (inc) begin
            ptr_q <= ptr_inc;
        end
    end

    assign value = ptr_q;

    a_load_in_range : assert property (
        @(posedge clk) disable iff (reset)
        load |-> (int'(load_value) < DEPTH)
    ) else $error("ring_counter: load value %0d out of range", load_value);

endmodule

//--- include/rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// free queue sizing
`define FL_DEPTH 128

// register file sizes
`define NUM_PHYS 128
`define NUM_ARCH 32

// branch checkpoint pages
`define NUM_CKPT 8

`endif
